//--- Makefile
TOP = tb_fifo_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f compile.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	if echo "$$out" | grep -qx "No errors"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf obj_dir

//--- compile.f
hw/fifo_pkg.sv
hw/fifo_write_side.sv
hw/fifo_buffer_core.sv
hw/fifo_read_side.sv
hw/fifo_top.sv
testbench/tb_fifo_top.sv

//--- hw/fifo_buffer_core.sv
`timescale 1ns/1ns

module fifo_buffer_core (
    input  logic                    fifo_vif,
    input  logic                    arst_n,
    input  fifo_pkg::fifo_wr_port_t wr_port,
    input  fifo_pkg::fifo_addr_t    rd_addr,
    input  logic                    rd_accept,
    output fifo_pkg::fifo_data_t    rd_word,
    output fifo_pkg::fifo_flags_t   flags
);

    localparam fifo_pkg::fifo_cnt_t CNT_FULL  = fifo_pkg::fifo_cnt_t'(fifo_pkg::FIFO_DEPTH);
    localparam fifo_pkg::fifo_cnt_t CNT_AFULL = fifo_pkg::fifo_cnt_t'(fifo_pkg::FIFO_DEPTH - 1);
    localparam fifo_pkg::fifo_cnt_t CNT_ONE   = fifo_pkg::fifo_cnt_t'(1);

    fifo_pkg::fifo_data_t mem [fifo_pkg::FIFO_DEPTH];
    fifo_pkg::fifo_cnt_t  count;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // No reset on the array, pointers and count say what is valid
    always_ff @(posedge fifo_vif) begin
        if (wr_port.we) begin
            mem[wr_port.addr] <= wr_port.data;
        end
    end

    assign rd_word = mem[rd_addr];   // Registered later on the read side

    ////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////

    // Strobes are already qualified by the two sides
    always_ff @(posedge fifo_vif or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({wr_port.we, rd_accept})
                2'b10:   count <= count + CNT_ONE;
                2'b01:   count <= count - CNT_ONE;
                default: count <= count;   // Idle or both together
            endcase
        end
    end

    ////////////////////////////////////////
    // Flag decode
    ////////////////////////////////////////

    always_comb begin
        flags.full         = (count == CNT_FULL);
        flags.empty        = (count == '0);
        flags.almost_full  = (count == CNT_AFULL);
        flags.almost_empty = (count == CNT_ONE);
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    property p_count_bound;
        @(posedge fifo_vif) disable iff (!arst_n)
            count <= CNT_FULL;
    endproperty

    a_count_bound : assert property (p_count_bound)
        else $error("count above depth: %0d", count);

    property p_full_empty_excl;
        @(posedge fifo_vif) disable iff (!arst_n)
            !(flags.full && flags.empty);
    endproperty

    a_full_empty_excl : assert property (p_full_empty_excl)
        else $error("full and empty both set");

    // Read side must hold off while nothing is stored
    property p_no_read_when_empty;
        @(posedge fifo_vif) disable iff (!arst_n)
            rd_accept |-> !flags.empty;
    endproperty

    a_no_read_when_empty : assert property (p_no_read_when_empty)
        else $error("rd_accept while empty");

endmodule

//--- hw/fifo_pkg.sv
package fifo_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int FIFO_WIDTH = 16;               // Bits per stored word
    localparam int FIFO_DEPTH = 8;                // Entries, power of two only
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = ADDR_W + 1;       // Extra bit so a full count fits

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [FIFO_WIDTH-1:0] fifo_data_t;   // One word
    typedef logic [ADDR_W-1:0]     fifo_addr_t;   // Memory index, wraps on its own
    typedef logic [CNT_W-1:0]      fifo_cnt_t;    // Occupancy 0..FIFO_DEPTH

    ////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////

    // Write request from outside
    typedef struct packed {
        logic       en;
        fifo_data_t data;
    } fifo_wr_req_t;

    // One-cycle pulses from the write side
    typedef struct packed {
        logic wr_ack;
        logic overflow;
    } fifo_wr_stat_t;

    // Status decoded from the count
    typedef struct packed {
        logic full;
        logic empty;
        logic almost_full;    // Count is depth minus one
        logic almost_empty;   // Count is one
    } fifo_flags_t;

    // Accepted write going into storage
    typedef struct packed {
        logic       we;       // Also the write-accept strobe
        fifo_addr_t addr;
        fifo_data_t data;
    } fifo_wr_port_t;

endpackage

//--- hw/fifo_read_side.sv
`timescale 1ns/1ns

module fifo_read_side (
    input  logic                  fifo_vif,
    input  logic                  arst_n,
    input  logic                  rd_en,
    input  fifo_pkg::fifo_flags_t flags,
    input  fifo_pkg::fifo_data_t  rd_word,
    output fifo_pkg::fifo_addr_t  rd_addr,
    output logic                  rd_accept,
    output fifo_pkg::fifo_data_t  data_out,
    output logic                  underflow
);

    fifo_pkg::fifo_addr_t rd_ptr;
    logic                 rd_reject;

    ////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////

    // Only place a read is decided
    assign rd_accept = rd_en && !flags.empty;
    assign rd_reject = rd_en &&  flags.empty;

    assign rd_addr = rd_ptr;   // Oldest word sits here

    ////////////////////////////////////////
    // Read pointer and data
    ////////////////////////////////////////

    always_ff @(posedge fifo_vif or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr   <= '0;
            data_out <= '0;
        end else if (rd_accept) begin
            data_out <= rd_word;                            // Holds until next read
            rd_ptr   <= rd_ptr + fifo_pkg::fifo_addr_t'(1);
        end
    end

    ////////////////////////////////////////
    // Underflow
    ////////////////////////////////////////

    always_ff @(posedge fifo_vif or negedge arst_n) begin
        if (!arst_n) begin
            underflow <= 1'b0;
        end else begin
            underflow <= rd_reject;   // One cycle pulse
        end
    end

    // A rejected read leaves the output word alone
    property p_underflow_keeps_data;
        @(posedge fifo_vif) disable iff (!arst_n)
            underflow |-> $stable(data_out);
    endproperty

    a_underflow_keeps_data : assert property (p_underflow_keeps_data)
        else $error("data_out changed on underflow");

endmodule

//--- hw/fifo_top.sv
`timescale 1ns/1ns

module fifo_top (
    input  logic                    fifo_vif,
    input  logic                    arst_n,
    input  fifo_pkg::fifo_wr_req_t  wr_req,
    input  logic                    rd_en,
    output fifo_pkg::fifo_data_t    data_out,
    output fifo_pkg::fifo_wr_stat_t wr_stat,
    output fifo_pkg::fifo_flags_t   flags
);

    ////////////////////////////////////////
    // Internal wires
    ////////////////////////////////////////

    fifo_pkg::fifo_wr_port_t wr_port;     // Accepted write into storage
    fifo_pkg::fifo_addr_t    rd_addr;
    logic                    rd_accept;
    fifo_pkg::fifo_data_t    rd_word;     // Word at the read pointer
    logic                    underflow;   // Not a top port, see below

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    fifo_write_side u_write_side (
        .fifo_vif (fifo_vif),
        .arst_n   (arst_n),
        .wr_req   (wr_req),
        .flags    (flags),
        .wr_port  (wr_port),
        .wr_stat  (wr_stat)
    );

    ////////////////////////////////////////
    // Storage and count
    ////////////////////////////////////////

    fifo_buffer_core u_buffer_core (
        .fifo_vif  (fifo_vif),
        .arst_n    (arst_n),
        .wr_port   (wr_port),
        .rd_addr   (rd_addr),
        .rd_accept (rd_accept),
        .rd_word   (rd_word),
        .flags     (flags)
    );

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    fifo_read_side u_read_side (
        .fifo_vif  (fifo_vif),
        .arst_n    (arst_n),
        .rd_en     (rd_en),
        .flags     (flags),
        .rd_word   (rd_word),
        .rd_addr   (rd_addr),
        .rd_accept (rd_accept),
        .data_out  (data_out),
        .underflow (underflow)
    );

endmodule

//--- hw/fifo_write_side.sv
`timescale 1ns/1ns

module fifo_write_side (
    input  logic                    fifo_vif,
    input  logic                    arst_n,
    input  fifo_pkg::fifo_wr_req_t  wr_req,
    input  fifo_pkg::fifo_flags_t   flags,
    output fifo_pkg::fifo_wr_port_t wr_port,
    output fifo_pkg::fifo_wr_stat_t wr_stat
);

    fifo_pkg::fifo_addr_t wr_ptr;
    logic                 wr_accept;
    logic                 wr_reject;

    ////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////

    // Only place a write is decided
    assign wr_accept = wr_req.en && !flags.full;
    assign wr_reject = wr_req.en &&  flags.full;   // Dropped, reported as overflow

    // Present the word at the current pointer
    assign wr_port.we   = wr_accept;
    assign wr_port.addr = wr_ptr;
    assign wr_port.data = wr_req.data;

    ////////////////////////////////////////
    // Write pointer
    ////////////////////////////////////////

    always_ff @(posedge fifo_vif or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + fifo_pkg::fifo_addr_t'(1);   // Natural wrap at depth
        end
    end

    ////////////////////////////////////////
    // Status pulses
    ////////////////////////////////////////

    // Both pulses last exactly one cycle after the edge
    always_ff @(posedge fifo_vif or negedge arst_n) begin
        if (!arst_n) begin
            wr_stat.wr_ack   <= 1'b0;
            wr_stat.overflow <= 1'b0;
        end else begin
            wr_stat.wr_ack   <= wr_accept;
            wr_stat.overflow <= wr_reject;
        end
    end

    // Accepted and rejected writes are exclusive, so the pulses never overlap
    property p_ack_ovf_exclusive;
        @(posedge fifo_vif) disable iff (!arst_n)
            !(wr_stat.wr_ack && wr_stat.overflow);
    endproperty

    a_ack_ovf_exclusive : assert property (p_ack_ovf_exclusive)
        else $error("wr_ack and overflow high together");

endmodule

//--- testbench/tb_fifo_top.sv
`timescale 1ns/1ns

module tb_fifo_top;

    localparam int          RESET_CYCLES  = 8;
    localparam int          RANDOM_CYCLES = 300;
    localparam logic [31:0] SEED          = 32'hf0d76908;
    localparam int          DEPTH         = fifo_pkg::FIFO_DEPTH;

    // Reset, fill, drain, edge cases and random traffic
    localparam int TEST_CYCLES = RESET_CYCLES + 2 + 2 * (DEPTH + 1) + (2 * DEPTH + 5)
                                 + RANDOM_CYCLES;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 50) * 10;

    logic                    fifo_vif;
    logic                    arst_n;
    fifo_pkg::fifo_wr_req_t  wr_req;
    logic                    rd_en;
    fifo_pkg::fifo_data_t    data_out;
    fifo_pkg::fifo_wr_stat_t wr_stat;
    fifo_pkg::fifo_flags_t   flags;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////

    fifo_pkg::fifo_data_t model_q[$];
    fifo_pkg::fifo_data_t exp_data_out;
    logic                 exp_wr_ack;
    logic                 exp_overflow;
    logic                 exp_underflow;
    fifo_pkg::fifo_data_t fill_words [DEPTH];   // Words of the fill test, in order
    logic [31:0]          rnd;

    fifo_top u_dut (
        .fifo_vif (fifo_vif),
        .arst_n   (arst_n),
        .wr_req   (wr_req),
        .rd_en    (rd_en),
        .data_out (data_out),
        .wr_stat  (wr_stat),
        .flags    (flags)
    );

    initial fifo_vif = 1'b0;
    always #5 fifo_vif = ~fifo_vif;   // 10 ns period

    ////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////

    task automatic fail_run();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input fifo_pkg::fifo_data_t got,
                              input fifo_pkg::fifo_data_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    // Every output against the model, flags from the model occupancy
    task automatic check_outputs();
        int n;
        n = model_q.size();
        check_word("data_out", data_out, exp_data_out);
        check_bit("wr_ack", wr_stat.wr_ack, exp_wr_ack);
        check_bit("overflow", wr_stat.overflow, exp_overflow);
        check_bit("underflow", u_dut.underflow, exp_underflow);   // Internal to the top
        check_bit("full", flags.full, n == DEPTH);
        check_bit("empty", flags.empty, n == 0);
        check_bit("almost_full", flags.almost_full, n == DEPTH - 1);
        check_bit("almost_empty", flags.almost_empty, n == 1);
    endtask

    // Called at a falling edge, returns at the next one after checking
    task automatic apply_cycle(input logic wen, input fifo_pkg::fifo_data_t wdata,
                               input logic ren);
        logic was_full;
        logic was_empty;
        was_full  = (model_q.size() == DEPTH);
        was_empty = (model_q.size() == 0);
        wr_req.en   = wen;
        wr_req.data = wdata;
        rd_en       = ren;

        exp_wr_ack    = wen && !was_full;
        exp_overflow  = wen && was_full;
        exp_underflow = ren && was_empty;
        if (ren && !was_empty) begin
            exp_data_out = model_q.pop_front();   // Oldest word leaves first
        end
        if (wen && !was_full) begin
            model_q.push_back(wdata);
        end

        @(negedge fifo_vif);
        check_outputs();
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reset_state_test();
        check_bit("empty", flags.empty, 1'b1);
        check_bit("full", flags.full, 1'b0);
        check_bit("almost_full", flags.almost_full, 1'b0);
        check_bit("almost_empty", flags.almost_empty, 1'b0);
        check_bit("wr_ack", wr_stat.wr_ack, 1'b0);
        check_bit("overflow", wr_stat.overflow, 1'b0);
        check_bit("underflow", u_dut.underflow, 1'b0);
        check_word("data_out", data_out, 16'h0000);
        apply_cycle(1'b0, '0, 1'b0);   // Idle cycle keeps everything quiet
    endtask

    task automatic fill_and_overflow_test();
        fifo_pkg::fifo_data_t w;
        for (int i = 0; i <= DEPTH; i++) begin
            w = 16'hc0de ^ fifo_pkg::fifo_data_t'(i * 32'h1357);
            if (i < DEPTH) begin
                fill_words[i] = w;
            end
            apply_cycle(1'b1, w, 1'b0);
            if (i == DEPTH - 2) begin
                check_bit("almost_full", flags.almost_full, 1'b1);
            end
            if (i == DEPTH - 1) begin
                check_bit("full", flags.full, 1'b1);
            end
            if (i == DEPTH) begin
                check_bit("overflow", wr_stat.overflow, 1'b1);
                check_bit("wr_ack", wr_stat.wr_ack, 1'b0);
            end else begin
                check_bit("wr_ack", wr_stat.wr_ack, 1'b1);
            end
        end
    endtask

    task automatic drain_and_underflow_test();
        for (int i = 0; i <= DEPTH; i++) begin
            apply_cycle(1'b0, '0, 1'b1);
            if (i < DEPTH) begin
                check_word("data_out", data_out, fill_words[i]);   // Write order
            end
            if (i == DEPTH - 2) begin
                check_bit("almost_empty", flags.almost_empty, 1'b1);
            end
            if (i == DEPTH - 1) begin
                check_bit("empty", flags.empty, 1'b1);
            end
            if (i == DEPTH) begin
                check_bit("underflow", u_dut.underflow, 1'b1);
                check_word("data_out", data_out, fill_words[DEPTH-1]);
            end
        end
    endtask

    task automatic simultaneous_test();
        for (int i = 0; i < DEPTH; i++) begin
            apply_cycle(1'b1, fifo_pkg::fifo_data_t'(16'h5a00 + i), 1'b0);
        end

        // At full only the read goes through
        apply_cycle(1'b1, 16'hdead, 1'b1);
        check_bit("wr_ack", wr_stat.wr_ack, 1'b0);
        check_bit("almost_full", flags.almost_full, 1'b1);
        check_word("count", fifo_pkg::fifo_data_t'(u_dut.u_buffer_core.count), 16'd7);

        for (int i = 0; i < DEPTH - 1; i++) begin
            apply_cycle(1'b0, '0, 1'b1);
        end

        // At empty only the write goes through
        apply_cycle(1'b1, 16'hbeef, 1'b1);
        check_bit("underflow", u_dut.underflow, 1'b1);
        check_bit("wr_ack", wr_stat.wr_ack, 1'b1);
        check_bit("almost_empty", flags.almost_empty, 1'b1);

        for (int i = 0; i < 3; i++) begin
            apply_cycle(1'b1, fifo_pkg::fifo_data_t'(16'h7700 + i), 1'b0);
        end

        // Mid occupancy, both accepted and the count stays at four
        apply_cycle(1'b1, 16'h1234, 1'b1);
        check_bit("wr_ack", wr_stat.wr_ack, 1'b1);
        check_word("data_out", data_out, 16'hbeef);
        check_word("count", fifo_pkg::fifo_data_t'(u_dut.u_buffer_core.count), 16'd4);
    endtask

    task automatic random_traffic_test();
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd = $urandom();
            apply_cycle(rnd[0], rnd[31:16], rnd[1]);
        end
        apply_cycle(1'b0, '0, 1'b0);
    endtask

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: the tests did not finish in %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        arst_n        = 1'b0;
        wr_req        = '0;
        rd_en         = 1'b0;
        exp_data_out  = '0;
        exp_wr_ack    = 1'b0;
        exp_overflow  = 1'b0;
        exp_underflow = 1'b0;
        rnd           = $urandom(SEED);   // Seeds the generator for the whole run

        repeat (RESET_CYCLES) @(posedge fifo_vif);
        @(negedge fifo_vif);
        arst_n = 1'b1;

        reset_state_test();
        fill_and_overflow_test();
        drain_and_underflow_test();
        simultaneous_test();
        random_traffic_test();

        $display("No errors");
        $finish;
    end

endmodule
